//--- sim.f
src/obj_attr_pkg.sv
src/obj_line_pkg.sv
src/obj_if.sv
src/oam_decoder.sv
src/sprite_line_walker.sv
src/pixel_merge.sv
src/gba_obj_drawer.sv
tb/obj_drawer_assertions.sv
tb/tb_gba_obj_drawer.sv

//--- tb/tb_gba_obj_drawer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gba_obj_drawer;

    localparam logic [31:0] SEED       = 32'h8013871a;
    localparam int          LINE_W     = 240;
    localparam int          RISE_LIMIT = 4;
    localparam int          LINE_LIMIT = 40000;
    // 128 objects at three cycles per decision, then the drain
    localparam int          MIN_LINE_CYCLES = 3 * 128 + 7;

    logic        fclk;
    logic        rst_n;
    logic        drawline;
    logic [7:0]  ypos;
    logic [7:0]  oam_addr;
    logic [31:0] oam_data;
    logic [12:0] vram_addr;
    logic [31:0] vram_data;
    logic        vram_busy;
    logic [6:0]  pal_addr;
    logic [31:0] pal_data;
    logic        busy;
    logic        pixel_we_color;
    logic [15:0] pixel_color;
    logic        pixel_we_settings;
    logic [1:0]  pixel_prio;
    logic [7:0]  pixel_x;

    // memory contents and the address each memory saw one cycle earlier
    logic [31:0] oam_mem [256];
    logic [31:0] vram_mem [8192];
    logic [31:0] pal_mem [128];
    logic [7:0]  oam_q;
    logic [12:0] vram_q;
    logic [6:0]  pal_q;

    // writes seen from the DUT during the current line
    logic [15:0] got_color [LINE_W];
    logic [1:0]  got_prio [LINE_W];
    logic        got_cw [LINE_W];
    logic        got_sw [LINE_W];
    int          write_count;
    int          stray_count;

    // model line buffer and expected writes
    logic [15:0] exp_color [LINE_W];
    logic [1:0]  exp_prio [LINE_W];
    logic        exp_cw [LINE_W];
    logic        exp_sw [LINE_W];
    logic        exp_trans [LINE_W];

    logic [31:0] rng;
    logic [31:0] noise_rng;
    logic        noise_on;
    int          checks;
    int          errors;
    int          tests;
    int          errors_before;
    int          rise_cycles;
    int          busy_cycles;

    gba_obj_drawer uut (.*);

    initial begin
        fclk = 1'b0;
        forever #10 fclk = ~fclk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // memories answer one cycle after the address
    always @(negedge fclk) begin
        oam_data  <= oam_mem[oam_q];
        vram_data <= vram_mem[vram_q];
        pal_data  <= pal_mem[pal_q];
        oam_q     <= oam_addr;
        vram_q    <= vram_addr;
        pal_q     <= pal_addr;
        if (noise_on) begin
            noise_rng = xorshift(noise_rng);
            vram_busy <= noise_rng[3] & noise_rng[9];
        end else begin
            vram_busy <= 1'b0;
        end
    end

    always @(negedge fclk) begin
        if (pixel_we_settings || pixel_we_color) begin
            write_count++;
            if (pixel_x >= LINE_W) begin
                stray_count++;
            end else begin
                if (pixel_we_settings) begin
                    got_sw[pixel_x]   = 1'b1;
                    got_prio[pixel_x] = pixel_prio;
                end
                if (pixel_we_color) begin
                    got_cw[pixel_x]    = 1'b1;
                    got_color[pixel_x] = pixel_color;
                end
            end
        end
    end

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("Result: FAILED");
        $finish;
    endtask

    // standard object size table in pixels
    task automatic obj_dims(input logic [1:0] shape, input logic [1:0] size,
                            output int w, output int h);
        int side [4]  = '{8, 16, 32, 64};
        int long_s [4] = '{16, 32, 32, 64};
        int short_s [4] = '{8, 8, 16, 32};
        case (shape)
            2'd0: begin
                w = side[size];
                h = side[size];
            end
            2'd1: begin
                w = long_s[size];
                h = short_s[size];
            end
            default: begin
                w = short_s[size];
                h = long_s[size];
            end
        endcase
    endtask

    function automatic logic [15:0] palette_color(input logic [7:0] idx);
        logic [31:0] word;
        word = pal_mem[idx[7:1]];
        return {1'b0, idx[0] ? word[30:16] : word[14:0]};
    endfunction

    task automatic merge_pixel(input int sx, input logic [1:0] p, input logic clear,
                               input logic [15:0] color);
        if (exp_trans[sx] || p < exp_prio[sx]) begin
            exp_sw[sx]   = 1'b1;
            exp_prio[sx] = p;
            if (!clear) begin
                exp_cw[sx]    = 1'b1;
                exp_color[sx] = color;
                exp_trans[sx] = 1'b0;
            end
        end
    endtask

    // replays OAM in index order for the current ypos
    task automatic model_line();
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] a2;
        logic [31:0] word;
        logic [7:0]  b;
        logic [7:0]  idx;
        logic        clear;
        int          w;
        int          h;
        int          y;
        int          row;
        int          x;
        int          sx;
        int          xp;
        int          tbytes;
        int          addr;
        for (int i = 0; i < LINE_W; i++) begin
            exp_sw[i]    = 1'b0;
            exp_cw[i]    = 1'b0;
            exp_trans[i] = 1'b1;
            exp_prio[i]  = 2'd3;
        end
        for (int n = 0; n < 128; n++) begin
            a0 = oam_mem[2 * n][15:0];
            a1 = oam_mem[2 * n][31:16];
            a2 = oam_mem[2 * n + 1][15:0];
            if (a0[8] || a0[9] || a0[15:14] == 2'd3)
                continue;
            obj_dims(a0[15:14], a1[15:14], w, h);
            y = a0[7:0];
            if (y > 256 - h)
                y = y - 256;
            row = int'(ypos) - y;
            if (row < 0 || row >= h)
                continue;
            if (a1[13])
                row = h - 1 - row;
            tbytes = a0[13] ? 64 : 32;
            x = a1[8] ? int'(a1[8:0]) - 512 : int'(a1[8:0]);
            for (int c = 0; c < w; c++) begin
                sx = x + c;
                if (sx >= LINE_W)
                    break;
                if (sx < 0)
                    continue;
                xp = a1[12] ? w - 1 - c : c;
                addr = int'(a2[9:0]) * 32 + (row / 8) * (w / 8) * tbytes + (xp / 8) * tbytes;
                if (a0[13])
                    addr = addr + (row % 8) * 8 + xp % 8;
                else
                    addr = addr + (row % 8) * 4 + (xp % 8) / 2;
                addr = addr % 32768;
                word = vram_mem[addr / 4];
                b = word[8 * (addr % 4) +: 8];
                if (a0[13]) begin
                    idx   = b;
                    clear = (b == 8'h00);
                end else begin
                    idx   = {a2[15:12], (xp % 2 == 1) ? b[7:4] : b[3:0]};
                    clear = (idx[3:0] == 4'h0);
                end
                merge_pixel(sx, a2[11:10], clear, palette_color(idx));
            end
        end
    endtask

    // one drawline pulse and the wait for busy to come and go
    task automatic run_line();
        int n;
        for (int i = 0; i < LINE_W; i++) begin
            got_sw[i] = 1'b0;
            got_cw[i] = 1'b0;
        end
        write_count = 0;
        stray_count = 0;
        drawline = 1'b1;
        @(negedge fclk);
        drawline = 1'b0;
        n = 1;
        while (!busy) begin
            if (n >= RISE_LIMIT)
                stop_on_timeout("busy did not rise after drawline");
            @(negedge fclk);
            n++;
        end
        rise_cycles = n;
        n = 0;
        while (busy) begin
            if (n >= LINE_LIMIT)
                stop_on_timeout("busy did not fall within the line limit");
            @(negedge fclk);
            n++;
        end
        busy_cycles = n;
    endtask

    task automatic compare_line(input string name);
        check_value({name, " writes past column 239"}, 0, stray_count);
        for (int x = 0; x < LINE_W; x++) begin
            check_value($sformatf("%s x=%0d settings write", name, x), exp_sw[x], got_sw[x]);
            check_value($sformatf("%s x=%0d color write", name, x), exp_cw[x], got_cw[x]);
            if (exp_sw[x] && got_sw[x])
                check_value($sformatf("%s x=%0d prio", name, x), exp_prio[x], got_prio[x]);
            if (exp_cw[x] && got_cw[x])
                check_value($sformatf("%s x=%0d color", name, x), exp_color[x], got_color[x]);
        end
    endtask

    task automatic draw_and_compare(input string name);
        run_line();
        model_line();
        compare_line(name);
    endtask

    task automatic fill_memories(input logic sparse);
        logic [31:0] r;
        for (int i = 0; i < 8192; i++) begin
            r = next_rand();
            // anding two words leaves many zero pixels
            vram_mem[i] = sparse ? (r & next_rand()) : r;
        end
        for (int i = 0; i < 128; i++)
            pal_mem[i] = next_rand();
    endtask

    task automatic clear_oam();
        for (int n = 0; n < 128; n++) begin
            oam_mem[2 * n]     = 32'h0000_0200;
            oam_mem[2 * n + 1] = next_rand();
        end
    endtask

    // objects on the line that must all be skipped
    task automatic skipped_oam();
        logic [31:0] r;
        logic [15:0] a0;
        for (int n = 0; n < 128; n++) begin
            r = next_rand();
            a0 = r[15:0];
            a0[7:0] = ypos;
            a0[9:8] = 2'b00;
            case (r[17:16])
                2'd0: a0[9] = 1'b1;
                2'd1: a0[15:14] = 2'd3;
                default: a0[8] = 1'b1;
            endcase
            oam_mem[2 * n]     = {r[31:16], a0};
            oam_mem[2 * n + 1] = next_rand();
        end
    endtask

    task automatic random_oam();
        logic [31:0] r;
        logic [31:0] r2;
        logic [15:0] a0;
        for (int n = 0; n < 128; n++) begin
            r  = next_rand();
            r2 = next_rand();
            a0 = r[15:0];
            a0[8] = 1'b0;
            a0[9] = r[16] & r[17];
            // about half of them land on the current line
            if (r[18])
                a0[7:0] = ypos - {2'b00, r[24:19]};
            oam_mem[2 * n]     = {r2[15:0], a0};
            oam_mem[2 * n + 1] = {16'h0000, r2[31:16]};
        end
    endtask

    // a pile of sprites around column 100 with only two priorities
    task automatic overlap_oam();
        logic [31:0] r;
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] a2;
        clear_oam();
        for (int n = 0; n < 12; n++) begin
            r  = next_rand();
            a0 = 16'h0000;
            a0[13]    = r[0];
            a0[15:14] = {1'b0, r[1]};
            a0[7:0]   = ypos - {5'b00000, r[4:2]};
            a1 = 16'h0000;
            a1[8:0]   = 9'(96 + r[8:5]);
            a1[12]    = r[9];
            a1[13]    = r[10];
            a1[15:14] = {1'b0, r[11]};
            a2 = r[31:16];
            a2[11:10] = {1'b0, r[12]};
            oam_mem[2 * n]     = {a1, a0};
            oam_mem[2 * n + 1] = {16'h0000, a2};
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        int          obj;
        rng           = SEED;
        noise_rng     = ~SEED;
        noise_on      = 1'b0;
        rst_n         = 1'b0;
        drawline      = 1'b0;
        ypos          = 8'd0;
        vram_busy     = 1'b0;
        oam_data      = '0;
        vram_data     = '0;
        pal_data      = '0;
        oam_q         = '0;
        vram_q        = '0;
        pal_q         = '0;
        checks        = 0;
        errors        = 0;
        tests         = 0;
        errors_before = 0;
        repeat (3) @(posedge fclk);
        @(negedge fclk);
        rst_n = 1'b1;

        check_value("reset busy", 0, busy);
        check_value("reset color write", 0, pixel_we_color);
        check_value("reset settings write", 0, pixel_we_settings);
        fill_memories(1'b0);
        clear_oam();
        ypos = 8'd40;
        run_line();
        check_value("busy rise delay", 1, rise_cycles);
        checks++;
        assert (busy_cycles >= MIN_LINE_CYCLES) else begin
            errors++;
            $display("busy fell after %0d cycles, before all objects were decided",
                     busy_cycles);
        end
        finish_test("reset and busy");

        ypos = 8'(next_rand() % 160);
        skipped_oam();
        run_line();
        check_value("skipped objects write count", 0, write_count);
        finish_test("skipped objects");

        // every hflip and vflip combination on one 8x8 4bpp sprite
        for (int f = 0; f < 4; f++) begin
            r    = next_rand();
            r2   = next_rand();
            ypos = 8'(r % 160);
            obj  = r[22:16];
            clear_oam();
            oam_mem[2 * obj] = {2'b00, f[1], f[0], 3'b000, 9'(r2 % 233),
                                8'h00, ypos - {5'b00000, r[10:8]}};
            oam_mem[2 * obj + 1] = {16'h0000, r2[31:16]};
            draw_and_compare($sformatf("flip %0d", f));
        end
        finish_test("single sprite flips");

        for (int k = 0; k < 4; k++) begin
            ypos = 8'(next_rand() % 160);
            random_oam();
            draw_and_compare($sformatf("random line %0d", k));
        end
        finish_test("random sprites");

        fill_memories(1'b1);
        for (int k = 0; k < 3; k++) begin
            ypos = 8'(next_rand() % 160);
            overlap_oam();
            draw_and_compare($sformatf("overlap line %0d", k));
        end
        finish_test("overlap priority");

        noise_on = 1'b1;
        for (int k = 0; k < 2; k++) begin
            ypos = 8'(next_rand() % 160);
            random_oam();
            draw_and_compare($sformatf("stalled random line %0d", k));
            ypos = 8'(next_rand() % 160);
            overlap_oam();
            draw_and_compare($sformatf("stalled overlap line %0d", k));
        end
        noise_on = 1'b0;
        finish_test("vram stalls");

        errors = errors + int'(uut.u_walker.u_assertions.fail_count);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/obj_drawer_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module obj_drawer_assertions (
    input logic        fclk,
    input logic        rst_n,
    input logic        req,
    input logic        ack,
    input logic        walking,
    input logic        issue,
    input logic        vram_busy,
    input logic [7:0]  target,
    input logic [12:0] vram_addr
);

    int unsigned fail_count = 0;

    // decoder keeps req up until the walker has taken the sprite
    req_until_ack: assert property (
        @(posedge fclk) disable iff (!rst_n) $fell(req) |-> $past(ack)
    ) else begin
        fail_count++;
        $error("req dropped before ack was raised");
    end

    // walker releases ack only after req is gone
    ack_after_req: assert property (
        @(posedge fclk) disable iff (!rst_n) $fell(ack) |-> !req
    ) else begin
        fail_count++;
        $error("ack dropped while req was still high");
    end

    // a stalled column is not issued and stays put for the next cycle
    stall_holds_column: assert property (
        @(posedge fclk) disable iff (!rst_n)
            walking && vram_busy |-> !issue ##1 ($stable(target) && $stable(vram_addr))
    ) else begin
        fail_count++;
        $error("column issued or moved on while vram_busy was high");
    end

endmodule

bind sprite_line_walker obj_drawer_assertions u_assertions (
    .fclk      (fclk),
    .rst_n     (rst_n),
    .req       (spr.req),
    .ack       (spr.ack),
    .walking   (state == W_WALK),
    .issue     (pix.issue),
    .vram_busy (vram_busy),
    .target    (pix.target),
    .vram_addr (vram_addr)
);

`default_nettype wire

//--- src/gba_obj_drawer.sv
`timescale 1ns/1ps
`default_nettype none

module gba_obj_drawer
    import obj_line_pkg::*;
(
    input  logic        fclk,
    input  logic        rst_n,
    input  logic        drawline,
    input  logic [7:0]  ypos,
    output logic [7:0]  oam_addr,
    input  logic [31:0] oam_data,
    output logic [12:0] vram_addr,
    input  logic [31:0] vram_data,
    input  logic        vram_busy,
    output logic [6:0]  pal_addr,
    input  logic [31:0] pal_data,
    output logic        busy,
    output logic        pixel_we_color,
    output logic [15:0] pixel_color,
    output logic        pixel_we_settings,
    output logic [1:0]  pixel_prio,
    output logic [7:0]  pixel_x
);

    sprite_if spr_bus ();
    fetch_if  fetch_bus ();

    oam_decoder u_decoder (
        .fclk     (fclk),
        .rst_n    (rst_n),
        .drawline (drawline),
        .ypos     (ypos),
        .oam_addr (oam_addr),
        .oam_data (oam_data),
        .busy     (busy),
        .spr      (spr_bus.dec)
    );

    sprite_line_walker u_walker (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .vram_busy (vram_busy),
        .vram_addr (vram_addr),
        .spr       (spr_bus.exe),
        .pix       (fetch_bus.exe)
    );

    pixel_merge #(
        .PIXELCOUNT (SCREEN_W)
    ) u_merge (
        .fclk              (fclk),
        .rst_n             (rst_n),
        .drawline          (drawline),
        .busy              (busy),
        .pix               (fetch_bus.res),
        .vram_data         (vram_data),
        .pal_data          (pal_data),
        .pal_addr          (pal_addr),
        .pixel_we_color    (pixel_we_color),
        .pixel_color       (pixel_color),
        .pixel_we_settings (pixel_we_settings),
        .pixel_prio        (pixel_prio),
        .pixel_x           (pixel_x)
    );

endmodule

`default_nettype wire

//--- src/pixel_merge.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_merge
    import obj_attr_pkg::*;
    import obj_line_pkg::*;
#(
    parameter int PIXELCOUNT = SCREEN_W
)
(
    input  logic        fclk,
    input  logic        rst_n,
    input  logic        drawline,
    input  logic        busy,
    fetch_if.res        pix,
    input  logic [31:0] vram_data,
    input  logic [31:0] pal_data,
    output logic [6:0]  pal_addr,
    output logic        pixel_we_color,
    output logic [15:0] pixel_color,
    output logic        pixel_we_settings,
    output logic [1:0]  pixel_prio,
    output logic [7:0]  pixel_x
);

    slot_t      lbuf [PIXELCOUNT];

    // stage 1, vram data arrives
    logic       en1;
    xpos_t      target1;
    logic [1:0] lane1;
    logic       odd1;
    logic       hicolor1;
    pal_bank_t  palette1;
    prio_t      prio1;
    logic [7:0] pix_byte;
    logic [3:0] nibble;
    logic [7:0] idx;
    logic       idx_clear;

    // stage 2, palette address out, line buffer read
    logic       en2;
    xpos_t      target2;
    logic [7:0] idx2;
    logic       trans2;
    prio_t      prio2;

    // stage 3, palette data arrives, merge
    logic       en3;
    xpos_t      target3;
    logic       half3;
    logic       trans3;
    prio_t      prio3;
    slot_t      rb3;
    logic       take;

    assign pal_addr = idx2[7:1];

    always_comb begin
        pix_byte = vram_data[{lane1, 3'b000} +: 8];
        nibble   = odd1 ? pix_byte[7:4] : pix_byte[3:0];
        if (hicolor1) begin
            idx       = pix_byte;
            idx_clear = (pix_byte == 8'h00);
        end else begin
            idx       = {palette1, nibble};
            idx_clear = (nibble == 4'h0);
        end
        // lower prio value wins, equal prio keeps the earlier object
        take = en3 && (rb3.transparent || prio3 < rb3.prio);
    end

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            en1               <= 1'b0;
            en2               <= 1'b0;
            en3               <= 1'b0;
            pixel_we_settings <= 1'b0;
            pixel_we_color    <= 1'b0;
        end else begin
            en1               <= pix.issue;
            en2               <= en1;
            en3               <= en2;
            pixel_we_settings <= take;
            pixel_we_color    <= take && !trans3;
        end
    end

    always_ff @(posedge fclk) begin
        target1  <= pix.target;
        lane1    <= pix.lane;
        odd1     <= pix.odd;
        hicolor1 <= pix.hicolor;
        palette1 <= pix.palette;
        prio1    <= pix.prio;

        target2  <= target1;
        idx2     <= idx;
        trans2   <= idx_clear;
        prio2    <= prio1;

        target3  <= target2;
        half3    <= idx2[0];
        trans3   <= trans2;
        prio3    <= prio2;
        rb3      <= lbuf[target2];

        pixel_x     <= target3;
        pixel_prio  <= prio3;
        pixel_color <= {1'b0, half3 ? pal_data[30:16] : pal_data[14:0]};
    end

    // line buffer, fresh for every line
    always_ff @(posedge fclk) begin
        if (!busy || drawline) begin
            for (int i = 0; i < PIXELCOUNT; i++)
                lbuf[i] <= '{transparent: 1'b1, prio: 2'd3};
        end else if (take) begin
            lbuf[target3].prio <= prio3;
            if (!trans3)
                lbuf[target3].transparent <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/sprite_line_walker.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_line_walker
    import obj_attr_pkg::*;
    import obj_line_pkg::*;
(
    input  logic        fclk,
    input  logic        rst_n,
    input  logic        vram_busy,
    output logic [12:0] vram_addr,
    sprite_if.exe       spr,
    fetch_if.exe        pix
);

    typedef enum logic [1:0] {W_IDLE, W_SETUP, W_WALK, W_FINISH} wstate_t;

    wstate_t     state;
    sprite_t     s;
    logic [6:0]  col;
    logic [14:0] line_base;
    logic [14:0] tile_bytes;
    logic [14:0] row_tiles;
    logic [5:0]  xp;
    logic [10:0] scr;
    logic        past_end;
    logic        on_screen;
    logic        walk_done;
    logic        advance;
    logic [14:0] byte_addr;

    always_comb begin
        tile_bytes = s.hicolor ? 15'(TILE_BYTES_8BPP) : 15'(TILE_BYTES_4BPP);
        // tile rows above the current one, 1D mapping
        row_tiles  = 15'(s.row[5:3]) * 15'(s.width[6:3]);
        xp         = 6'(s.hflip ? s.width - 7'd1 - col : col);
        scr        = {s.x[9], s.x} + {4'b0000, col};
        on_screen  = !scr[10];
        past_end   = on_screen && (scr[9:0] > 10'(SCREEN_W - 1));
        walk_done  = (col == s.width) || past_end;
        advance    = (state == W_WALK) && !walk_done && !vram_busy;
        // two pixels per byte in 4bpp
        byte_addr  = line_base + 15'(xp[5:3]) * tile_bytes
                   + (s.hicolor ? 15'(xp[2:0]) : 15'(xp[2:1]));
    end

    assign vram_addr   = byte_addr[14:2];
    assign pix.issue   = advance && on_screen;
    assign pix.target  = scr[7:0];
    assign pix.lane    = byte_addr[1:0];
    assign pix.odd     = xp[0];
    assign pix.hicolor = s.hicolor;
    assign pix.palette = s.palette;
    assign pix.prio    = s.prio;

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= W_IDLE;
            spr.ack <= 1'b0;
            col     <= '0;
        end else begin
            case (state)
                W_IDLE:
                    if (spr.req) begin
                        spr.ack <= 1'b1;
                        col     <= '0;
                        state   <= W_SETUP;
                    end
                W_SETUP:
                    state <= W_WALK;
                W_WALK: begin
                    if (walk_done)
                        state <= W_FINISH;
                    // vram_busy holds the column
                    if (advance)
                        col <= col + 7'd1;
                end
                W_FINISH:
                    if (!spr.req) begin
                        spr.ack <= 1'b0;
                        state   <= W_IDLE;
                    end
                default:
                    state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge fclk) begin
        if (state == W_IDLE && spr.req)
            s <= spr.sprite;
        // start of the current pixel row inside the sprite
        if (state == W_SETUP)
            line_base <= s.tile_base + row_tiles * tile_bytes
                       + (s.hicolor ? {9'd0, s.row[2:0], 3'd0} : {10'd0, s.row[2:0], 2'd0});
    end

endmodule

`default_nettype wire

//--- src/oam_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module oam_decoder
    import obj_attr_pkg::*;
(
    input  logic        fclk,
    input  logic        rst_n,
    input  logic        drawline,
    input  logic [7:0]  ypos,
    output logic [7:0]  oam_addr,
    input  logic [31:0] oam_data,
    output logic        busy,
    sprite_if.dec       spr
);

    localparam logic [2:0] DRAIN_CYCLES = 3'd7;

    typedef enum logic [2:0] {S_IDLE, S_RD0, S_RD1, S_EVAL, S_SEND, S_HOLD} state_t;

    state_t     state;
    logic [6:0] obj;
    logic [2:0] drain;
    attr0_t     a0;
    attr1_t     a1;
    attr2_t     a2;
    obj_dim_t   dim;
    logic [9:0] posy;
    logic [9:0] row;
    logic       hit;
    logic       skip;
    logic [5:0] row_flip;
    logic       last_obj;
    logic       walker_idle;
    logic       obj_done;

    // attribute 2 arrives in the decision cycle itself
    assign a2          = attr2_t'(oam_data[15:0]);
    assign dim         = obj_size(a0.shape, a1.size);
    assign last_obj    = (obj == 7'(OBJ_COUNT - 1));
    assign walker_idle = !spr.req && !spr.ack;
    assign obj_done    = (state == S_EVAL && skip) || (state == S_HOLD && spr.ack);

    always_comb begin
        // objects hanging over the top edge wrap to negative y
        if ({1'b0, a0.y} > 9'd256 - {2'b00, dim.h})
            posy = {2'b00, a0.y} - 10'd256;
        else
            posy = {2'b00, a0.y};
        row      = {2'b00, ypos} - posy;
        hit      = !row[9] && (row < {3'b000, dim.h});
        row_flip = a1.vflip ? 6'(dim.h - 7'd1 - row[6:0]) : row[5:0];
        // affine and double size objects are not drawn at all
        skip     = a0.affine || a0.disable_dbl || (a0.shape == 2'd3) || !hit;
    end

    always_ff @(posedge fclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            obj      <= '0;
            oam_addr <= '0;
            busy     <= 1'b0;
            drain    <= '0;
            spr.req  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    // hold busy until the walker and the pixel pipe are empty
                    if (busy) begin
                        if (!walker_idle)
                            drain <= DRAIN_CYCLES;
                        else if (drain != 3'd0)
                            drain <= drain - 3'd1;
                        else
                            busy <= 1'b0;
                    end
                    if (drawline) begin
                        busy     <= 1'b1;
                        obj      <= '0;
                        oam_addr <= '0;
                        state    <= S_RD0;
                    end
                end
                S_RD0: begin
                    oam_addr <= oam_addr + 8'd1;
                    state    <= S_RD1;
                end
                S_RD1:
                    state <= S_EVAL;
                S_EVAL:
                    if (!skip)
                        state <= S_SEND;
                S_SEND:
                    // previous sprite line must be finished first
                    if (!spr.ack) begin
                        spr.req <= 1'b1;
                        state   <= S_HOLD;
                    end
                S_HOLD:
                    if (spr.ack)
                        spr.req <= 1'b0;
                default:
                    state <= S_IDLE;
            endcase

            if (obj_done) begin
                if (last_obj) begin
                    state <= S_IDLE;
                    drain <= DRAIN_CYCLES;
                end else begin
                    obj      <= obj + 7'd1;
                    oam_addr <= {obj + 7'd1, 1'b0};
                    state    <= S_RD0;
                end
            end
        end
    end

    always_ff @(posedge fclk) begin
        if (state == S_RD1) begin
            a0 <= attr0_t'(oam_data[15:0]);
            a1 <= attr1_t'(oam_data[31:16]);
        end
        if (state == S_EVAL && !skip) begin
            spr.sprite.x         <= {a1.x[8], a1.x};
            spr.sprite.width     <= dim.w;
            spr.sprite.height    <= dim.h;
            spr.sprite.row       <= row_flip;
            spr.sprite.hflip     <= a1.hflip;
            spr.sprite.hicolor   <= a0.hicolor;
            spr.sprite.prio      <= a2.prio;
            spr.sprite.palette   <= a2.palette;
            spr.sprite.tile_base <= 15'(a2.tile) * 15'(TILE_BYTES_4BPP);
        end
    end

endmodule

`default_nettype wire

//--- src/obj_if.sv
`timescale 1ns/1ps
`default_nettype none

// decoded sprite, four-phase req/ack
interface sprite_if
    import obj_attr_pkg::*;
();
    logic    req;
    logic    ack;
    sprite_t sprite;

    modport dec (output req, output sprite, input ack);
    modport exe (input req, input sprite, output ack);
endinterface

// one pixel per cycle towards the merge stage, no back-pressure
interface fetch_if
    import obj_attr_pkg::*, obj_line_pkg::*;
();
    logic      issue;
    xpos_t     target;
    logic [1:0] lane;
    logic      odd;
    logic      hicolor;
    pal_bank_t palette;
    prio_t     prio;

    modport exe (
        output issue, output target, output lane, output odd,
        output hicolor, output palette, output prio
    );
    modport res (
        input issue, input target, input lane, input odd,
        input hicolor, input palette, input prio
    );
endinterface

`default_nettype wire

//--- src/obj_line_pkg.sv
`default_nettype none

package obj_line_pkg;

    localparam int SCREEN_W = 240;

    typedef logic [7:0] xpos_t;

    // line buffer entry, cleared to transparent with prio 3
    typedef struct packed {
        logic       transparent;
        logic [1:0] prio;
    } slot_t;

endpackage

`default_nettype wire

//--- src/obj_attr_pkg.sv
`default_nettype none

package obj_attr_pkg;

    localparam int OBJ_COUNT       = 128;
    localparam int TILE_BYTES_4BPP = 32;
    localparam int TILE_BYTES_8BPP = 64;

    typedef logic [1:0] prio_t;
    typedef logic [3:0] pal_bank_t;

    // attribute 0, lower half of OAM word 2n
    typedef struct packed {
        logic [1:0] shape;
        logic       hicolor;
        logic       mosaic;
        logic [1:0] mode;
        logic       disable_dbl;
        logic       affine;
        logic [7:0] y;
    } attr0_t;

    // attribute 1, upper half of OAM word 2n
    typedef struct packed {
        logic [1:0] size;
        logic       vflip;
        logic       hflip;
        logic [2:0] unused;
        logic [8:0] x;
    } attr1_t;

    typedef struct packed {
        pal_bank_t  palette;
        prio_t      prio;
        logic [9:0] tile;
    } attr2_t;

    // one sprite line as handed from decoder to walker
    typedef struct packed {
        logic signed [9:0] x;
        logic [6:0]        width;
        logic [6:0]        height;
        logic [5:0]        row;
        logic              hflip;
        logic              hicolor;
        prio_t             prio;
        pal_bank_t         palette;
        logic [14:0]       tile_base;
    } sprite_t;

    typedef struct packed {
        logic [6:0] w;
        logic [6:0] h;
    } obj_dim_t;

    // shape 0 square, 1 wide, 2 tall
    function automatic obj_dim_t obj_size(input logic [1:0] shape, input logic [1:0] size);
        obj_dim_t d;
        case ({shape, size})
            4'b00_00: d = '{w: 7'd8,  h: 7'd8};
            4'b00_01: d = '{w: 7'd16, h: 7'd16};
            4'b00_10: d = '{w: 7'd32, h: 7'd32};
            4'b00_11: d = '{w: 7'd64, h: 7'd64};
            4'b01_00: d = '{w: 7'd16, h: 7'd8};
            4'b01_01: d = '{w: 7'd32, h: 7'd8};
            4'b01_10: d = '{w: 7'd32, h: 7'd16};
            4'b01_11: d = '{w: 7'd64, h: 7'd32};
            4'b10_00: d = '{w: 7'd8,  h: 7'd16};
            4'b10_01: d = '{w: 7'd8,  h: 7'd32};
            4'b10_10: d = '{w: 7'd16, h: 7'd32};
            4'b10_11: d = '{w: 7'd32, h: 7'd64};
            default:  d = '{w: 7'd8,  h: 7'd8};
        endcase
        return d;
    endfunction

endpackage

`default_nettype wire
